// ==== Bender.yml ====
package:
  name: mips_execute

sources:
  - logic/mips_alu_pkg.sv
  - logic/mips_isa_pkg.sv
  - logic/delay_line.sv
  - logic/alu_core.sv
  - logic/alu_hilo.sv
  - logic/alu_decode.sv
  - logic/mips_execute.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/mips_execute_sva.sv
      - testbench/tb_mips_execute.sv

// ==== logic/alu_core.sv ====
`timescale 1ns/1ps

module alu_core
	( input  logic [mips_alu_pkg::DATA_W-1:0]   data1
	, input  logic [mips_alu_pkg::DATA_W-1:0]   data2
	, input  logic [mips_alu_pkg::DATA_W-1:0]   reg_hi
	, input  logic [mips_alu_pkg::DATA_W-1:0]   reg_lo
	, input  logic [mips_alu_pkg::FUNC_W-1:0]   func
	, input  logic [mips_alu_pkg::SHAMT_W-1:0]  shamt
	, output logic [mips_alu_pkg::DATA_W-1:0]   res_hi
	, output logic [mips_alu_pkg::DATA_W-1:0]   res_lo
	, output logic [mips_alu_pkg::STATUS_W-1:0] status
	);

import mips_alu_pkg::*;

logic        [DATA_W-1:0]   sum;
logic        [DATA_W-1:0]   diff;
logic        [2*DATA_W-1:0] prod_u;
logic signed [2*DATA_W-1:0] prod_s;
logic        [DATA_W-1:0]   den_u;
logic        [DATA_W-1:0]   quot_u;
logic        [DATA_W-1:0]   rem_u;
logic signed [DATA_W-1:0]   den_s;
logic signed [DATA_W-1:0]   quot_s;
logic signed [DATA_W-1:0]   rem_s;
logic                       div_zero;
logic                       min_by_neg1;
logic                       ovf;

assign sum  = data1 + data2;
assign diff = data1 - data2;

assign prod_u = {{DATA_W{1'b0}}, data1} * {{DATA_W{1'b0}}, data2};
assign prod_s = $signed(data1) * $signed(data2);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

assign div_zero    = data2 == '0;
assign min_by_neg1 = (data1 == {1'b1, {(DATA_W-1){1'b0}}}) && (&data2);

// dividing by one gives the min/-1 answer directly (quotient = dividend, rem 0)
assign den_u  = div_zero ? DATA_W'(1) : data2;
assign den_s  = (div_zero || min_by_neg1) ? DATA_W'(1) : data2;
assign quot_u = data1 / den_u;
assign rem_u  = data1 % den_u;
assign quot_s = $signed(data1) / den_s;
assign rem_s  = $signed(data1) % den_s;

always_comb begin
	res_hi = '0;
	res_lo = '0;
	ovf    = 1'b0;
	case (func)
		FUNC_ADD: begin
			res_lo = sum;
			ovf    = (data1[DATA_W-1] == data2[DATA_W-1])
			         && (sum[DATA_W-1] != data1[DATA_W-1]);
		end
		FUNC_ADDU: res_lo = sum;
		FUNC_SUB: begin
			res_lo = diff;
			ovf    = (data1[DATA_W-1] != data2[DATA_W-1])
			         && (diff[DATA_W-1] != data1[DATA_W-1]);
		end
		FUNC_SUBU: res_lo = diff;
		FUNC_AND:  res_lo = data1 & data2;
		FUNC_OR:   res_lo = data1 | data2;
		FUNC_XOR:  res_lo = data1 ^ data2;
		FUNC_NOR:  res_lo = ~(data1 | data2);
		FUNC_SLT:  res_lo = DATA_W'($signed(data1) < $signed(data2));
		FUNC_SLTU: res_lo = DATA_W'(data1 < data2);
		FUNC_SLL:  res_lo = data1 << shamt;
		FUNC_SRL:  res_lo = data1 >> shamt;
		FUNC_SRA:  res_lo = $signed(data1) >>> shamt;
		FUNC_LUI:  res_lo = data2 << 16;
		FUNC_MULU: {res_hi, res_lo} = prod_u;
		FUNC_MULS: {res_hi, res_lo} = prod_s;
		FUNC_DIVU: begin
			res_lo = div_zero ? '1 : quot_u;
			res_hi = div_zero ? data1 : rem_u;
		end
		FUNC_DIVS: begin
			res_lo = div_zero ? '1 : quot_s;
			res_hi = div_zero ? data1 : rem_s;
		end
		FUNC_MFHI: res_lo = reg_hi;
		FUNC_MFLO: res_lo = reg_lo;
		// hilo block picks which half is stored
		FUNC_MTHI, FUNC_MTLO: begin
			res_hi = data1;
			res_lo = data1;
		end
		default: ;
	endcase
end

assign status[ST_ZERO] = res_lo == '0;
assign status[ST_NEG]  = res_lo[DATA_W-1];
assign status[ST_OVF]  = ovf;
assign status[ST_DIVZ] = div_zero && (func == FUNC_DIVU || func == FUNC_DIVS);

endmodule

// ==== logic/alu_decode.sv ====
`timescale 1ns/1ps

module alu_decode
	( input  mips_isa_pkg::instr_t                instr
	, input  logic [mips_alu_pkg::DATA_W-1:0]     rs_val
	, input  logic [mips_alu_pkg::DATA_W-1:0]     rt_val
	, output logic [mips_alu_pkg::FUNC_W-1:0]     func
	, output logic [mips_alu_pkg::DATA_W-1:0]     data1
	, output logic [mips_alu_pkg::DATA_W-1:0]     data2
	, output logic [mips_alu_pkg::SHAMT_W-1:0]    shamt
	);

import mips_alu_pkg::*;
import mips_isa_pkg::*;

logic [DATA_W-1:0] imm_sext;
logic [DATA_W-1:0] imm_zext;
logic              unknown;

assign imm_sext = {{(DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
assign imm_zext = {{(DATA_W-16){1'b0}}, instr.i.imm};

always_comb begin
	func    = FUNC_SLL;
	data1   = rs_val;
	data2   = rt_val;
	shamt   = '0;
	unknown = 1'b0;
	if (instr.r.opcode == OP_SPECIAL) begin
		// shifts live in funct 0x00..0x07, bit 2 selects the variable form
		if (instr.r.funct[5:3] == 3'b000) begin
			data1 = rt_val;
			shamt = instr.r.funct[2] ? rs_val[SHAMT_W-1:0] : instr.r.shamt;
		end
		case (instr.r.funct)
			FN_SLL, FN_SLLV: func = FUNC_SLL;
			FN_SRL, FN_SRLV: func = FUNC_SRL;
			FN_SRA, FN_SRAV: func = FUNC_SRA;
			FN_MFHI:         func = FUNC_MFHI;
			FN_MTHI:         func = FUNC_MTHI;
			FN_MFLO:         func = FUNC_MFLO;
			FN_MTLO:         func = FUNC_MTLO;
			FN_MULT:         func = FUNC_MULS;
			FN_MULTU:        func = FUNC_MULU;
			FN_DIV:          func = FUNC_DIVS;
			FN_DIVU:         func = FUNC_DIVU;
			FN_ADD:          func = FUNC_ADD;
			FN_ADDU:         func = FUNC_ADDU;
			FN_SUB:          func = FUNC_SUB;
			FN_SUBU:         func = FUNC_SUBU;
			FN_AND:          func = FUNC_AND;
			FN_OR:           func = FUNC_OR;
			FN_XOR:          func = FUNC_XOR;
			FN_NOR:          func = FUNC_NOR;
			FN_SLT:          func = FUNC_SLT;
			FN_SLTU:         func = FUNC_SLTU;
			default:         unknown = 1'b1;
		endcase
	end else begin
		// logical immediates and lui (0x0c..0x0f) take the zero-extended form
		data2 = instr.i.opcode[2] ? imm_zext : imm_sext;
		case (instr.i.opcode)
			OP_ADDI:  func = FUNC_ADD;
			OP_ADDIU: func = FUNC_ADDU;
			OP_SLTI:  func = FUNC_SLT;
			OP_SLTIU: func = FUNC_SLTU;
			OP_ANDI:  func = FUNC_AND;
			OP_ORI:   func = FUNC_OR;
			OP_XORI:  func = FUNC_XOR;
			OP_LUI:   func = FUNC_LUI;
			default:  unknown = 1'b1;
		endcase
	end
	// anything unrecognised becomes sll 0 by 0, a zero result
	if (unknown) begin
		func  = FUNC_SLL;
		data1 = '0;
		data2 = '0;
		shamt = '0;
	end
end

endmodule

// ==== logic/alu_hilo.sv ====
`timescale 1ns/1ps

module alu_hilo
	( input  logic                                clk
	, input  logic                                rst_n
	, input  logic [mips_alu_pkg::DATA_W-1:0]     data1
	, input  logic [mips_alu_pkg::DATA_W-1:0]     data2
	, input  logic [mips_alu_pkg::FUNC_W-1:0]     func
	, input  logic [mips_alu_pkg::SHAMT_W-1:0]    shamt
	, output logic [mips_alu_pkg::DATA_W-1:0]     result
	, output logic [mips_alu_pkg::STATUS_W-1:0]   status
	);

import mips_alu_pkg::*;

logic [DATA_W-1:0]   reg_hi;
logic [DATA_W-1:0]   reg_lo;
logic [DATA_W-1:0]   res_hi;
logic [DATA_W-1:0]   res_lo;
logic [STATUS_W-1:0] core_status;
logic                store_hi;
logic                store_lo;

alu_core u_core
	( .data1  (data1)
	, .data2  (data2)
	, .reg_hi (reg_hi)
	, .reg_lo (reg_lo)
	, .func   (func)
	, .shamt  (shamt)
	, .res_hi (res_hi)
	, .res_lo (res_lo)
	, .status (core_status)
	);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HI/LO write enables and registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
	case (func)
		FUNC_MULU, FUNC_MULS, FUNC_DIVU, FUNC_DIVS: {store_hi, store_lo} = 2'b11;
		FUNC_MTHI: {store_hi, store_lo} = 2'b10;
		FUNC_MTLO: {store_hi, store_lo} = 2'b01;
		default:   {store_hi, store_lo} = 2'b00;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		reg_hi <= '0;
		reg_lo <= '0;
	end else begin
		if (store_hi)
			reg_hi <= res_hi;
		if (store_lo)
			reg_lo <= res_lo;
	end
end

// result and status leave EXEC_DELAY edges later
delay_line #(.WIDTH(DATA_W), .DELAY(EXEC_DELAY)) u_dly_result
	( .clk   (clk)
	, .rst_n (rst_n)
	, .in    (res_lo)
	, .out   (result)
	);

delay_line #(.WIDTH(STATUS_W), .DELAY(EXEC_DELAY)) u_dly_status
	( .clk   (clk)
	, .rst_n (rst_n)
	, .in    (core_status)
	, .out   (status)
	);

endmodule

// ==== logic/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #
	( parameter int WIDTH = 1
	, parameter int DELAY = 1
	)
	( input  logic             clk
	, input  logic             rst_n
	, input  logic [WIDTH-1:0] in
	, output logic [WIDTH-1:0] out
	);

generate
	if (DELAY == 0) begin : g_wire
		assign out = in;
	end else begin : g_chain
		logic [WIDTH-1:0] stage [DELAY];

		// stage 0 takes the input, the last stage drives out
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				for (int i = 0; i < DELAY; i++)
					stage[i] <= '0;
			end else begin
				stage[0] <= in;
				for (int i = 1; i < DELAY; i++)
					stage[i] <= stage[i-1];
			end
		end

		assign out = stage[DELAY-1];
	end
endgenerate

endmodule

// ==== logic/mips_alu_pkg.sv ====
package mips_alu_pkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int DATA_W  = 32;
localparam int SHAMT_W = 5;
localparam int FUNC_W  = 5;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU function codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam logic [FUNC_W-1:0] FUNC_ADD  = 5'd0;
localparam logic [FUNC_W-1:0] FUNC_ADDU = 5'd1;
localparam logic [FUNC_W-1:0] FUNC_SUB  = 5'd2;
localparam logic [FUNC_W-1:0] FUNC_SUBU = 5'd3;
localparam logic [FUNC_W-1:0] FUNC_AND  = 5'd4;
localparam logic [FUNC_W-1:0] FUNC_OR   = 5'd5;
localparam logic [FUNC_W-1:0] FUNC_XOR  = 5'd6;
localparam logic [FUNC_W-1:0] FUNC_NOR  = 5'd7;
localparam logic [FUNC_W-1:0] FUNC_SLT  = 5'd8;
localparam logic [FUNC_W-1:0] FUNC_SLTU = 5'd9;
localparam logic [FUNC_W-1:0] FUNC_SLL  = 5'd10;
localparam logic [FUNC_W-1:0] FUNC_SRL  = 5'd11;
localparam logic [FUNC_W-1:0] FUNC_SRA  = 5'd12;
localparam logic [FUNC_W-1:0] FUNC_LUI  = 5'd13;
localparam logic [FUNC_W-1:0] FUNC_MULU = 5'd14;
localparam logic [FUNC_W-1:0] FUNC_MULS = 5'd15;
localparam logic [FUNC_W-1:0] FUNC_DIVU = 5'd16;
localparam logic [FUNC_W-1:0] FUNC_DIVS = 5'd17;
localparam logic [FUNC_W-1:0] FUNC_MFHI = 5'd18;
localparam logic [FUNC_W-1:0] FUNC_MFLO = 5'd19;
localparam logic [FUNC_W-1:0] FUNC_MTHI = 5'd20;
localparam logic [FUNC_W-1:0] FUNC_MTLO = 5'd21;

// status vector, one flag per bit
localparam int STATUS_W = 4;
localparam int ST_ZERO  = 0;
localparam int ST_NEG   = 1;
localparam int ST_OVF   = 2;
localparam int ST_DIVZ  = 3;

// result and status latency through the execute stage
localparam int EXEC_DELAY = 1;

endpackage

// ==== logic/mips_execute.sv ====
`timescale 1ns/1ps

module mips_execute
	( input  logic                                clk
	, input  logic                                rst_n
	, input  mips_isa_pkg::instr_t                instr
	, input  logic [mips_alu_pkg::DATA_W-1:0]     rs_val
	, input  logic [mips_alu_pkg::DATA_W-1:0]     rt_val
	, output logic [mips_alu_pkg::DATA_W-1:0]     result
	, output logic [mips_alu_pkg::STATUS_W-1:0]   status
	);

import mips_alu_pkg::*;

// decoded operation, valid in the same cycle as instr
logic [FUNC_W-1:0]  func;
logic [DATA_W-1:0]  data1;
logic [DATA_W-1:0]  data2;
logic [SHAMT_W-1:0] shamt;

alu_decode u_decode
	( .instr  (instr)
	, .rs_val (rs_val)
	, .rt_val (rt_val)
	, .func   (func)
	, .data1  (data1)
	, .data2  (data2)
	, .shamt  (shamt)
	);

alu_hilo u_alu
	( .clk    (clk)
	, .rst_n  (rst_n)
	, .data1  (data1)
	, .data2  (data2)
	, .func   (func)
	, .shamt  (shamt)
	, .result (result)
	, .status (status)
	);

endmodule

// ==== logic/mips_isa_pkg.sv ====
package mips_isa_pkg;

// register format
typedef struct packed {
	logic [5:0] opcode;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] shamt;
	logic [5:0] funct;
} instr_r_t;

// immediate format
typedef struct packed {
	logic [5:0]  opcode;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [15:0] imm;
} instr_i_t;

typedef union packed {
	instr_r_t r;
	instr_i_t i;
} instr_t;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// primary opcodes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_ADDI    = 6'h08;
localparam logic [5:0] OP_ADDIU   = 6'h09;
localparam logic [5:0] OP_SLTI    = 6'h0a;
localparam logic [5:0] OP_SLTIU   = 6'h0b;
localparam logic [5:0] OP_ANDI    = 6'h0c;
localparam logic [5:0] OP_ORI     = 6'h0d;
localparam logic [5:0] OP_XORI    = 6'h0e;
localparam logic [5:0] OP_LUI     = 6'h0f;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPECIAL funct field
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam logic [5:0] FN_SLL   = 6'h00;
localparam logic [5:0] FN_SRL   = 6'h02;
localparam logic [5:0] FN_SRA   = 6'h03;
localparam logic [5:0] FN_SLLV  = 6'h04;
localparam logic [5:0] FN_SRLV  = 6'h06;
localparam logic [5:0] FN_SRAV  = 6'h07;
localparam logic [5:0] FN_MFHI  = 6'h10;
localparam logic [5:0] FN_MTHI  = 6'h11;
localparam logic [5:0] FN_MFLO  = 6'h12;
localparam logic [5:0] FN_MTLO  = 6'h13;
localparam logic [5:0] FN_MULT  = 6'h18;
localparam logic [5:0] FN_MULTU = 6'h19;
localparam logic [5:0] FN_DIV   = 6'h1a;
localparam logic [5:0] FN_DIVU  = 6'h1b;
localparam logic [5:0] FN_ADD   = 6'h20;
localparam logic [5:0] FN_ADDU  = 6'h21;
localparam logic [5:0] FN_SUB   = 6'h22;
localparam logic [5:0] FN_SUBU  = 6'h23;
localparam logic [5:0] FN_AND   = 6'h24;
localparam logic [5:0] FN_OR    = 6'h25;
localparam logic [5:0] FN_XOR   = 6'h26;
localparam logic [5:0] FN_NOR   = 6'h27;
localparam logic [5:0] FN_SLT   = 6'h2a;
localparam logic [5:0] FN_SLTU  = 6'h2b;

endpackage

// ==== tb.f ====
logic/mips_alu_pkg.sv
logic/mips_isa_pkg.sv
logic/delay_line.sv
logic/alu_core.sv
logic/alu_hilo.sv
logic/alu_decode.sv
logic/mips_execute.sv
testbench/tb_clock.sv
testbench/mips_execute_sva.sv
testbench/tb_mips_execute.sv

// ==== testbench/mips_execute_sva.sv ====
`timescale 1ns/1ps

module mips_execute_sva
	( input logic                                clk
	, input logic                                rst_n
	, input logic [mips_alu_pkg::DATA_W-1:0]     result
	, input logic [mips_alu_pkg::STATUS_W-1:0]   status
	);

import mips_alu_pkg::*;

// count of failed assertions, read by the testbench
int fails = 0;

// zero flag follows the result once real data reaches the outputs
zero_flag_tracks_result: assert property (@(posedge clk) disable iff (!rst_n)
	$past(rst_n, EXEC_DELAY) |-> status[ST_ZERO] == (result == '0))
	else begin
		$error("zero flag differs from result");
		fails++;
	end

// delay stages still hold their reset value on the first edge after release
clean_after_reset: assert property (@(posedge clk)
	$rose(rst_n) |-> (result == '0) && (status == '0))
	else begin
		$error("outputs not zero right after reset");
		fails++;
	end

ovf_excludes_divz: assert property (@(posedge clk)
	!(status[ST_OVF] && status[ST_DIVZ]))
	else begin
		$error("overflow and divide by zero flagged together");
		fails++;
	end

endmodule

bind mips_execute mips_execute_sva u_sva
	( .clk    (clk)
	, .rst_n  (rst_n)
	, .result (result)
	, .status (status)
	);

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #
	( parameter real PERIOD       = 40.0
	, parameter int  RESET_CYCLES = 4
	)
	( output logic clk
	, output logic rst_n
	);

initial begin
	clk = 1'b0;
	forever #(PERIOD / 2.0) clk = ~clk;
end

// reset held over RESET_CYCLES rising edges, released on a falling edge
initial begin
	rst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
end

endmodule

// ==== testbench/tb_mips_execute.sv ====
`timescale 1ns/1ps

module tb_mips_execute;

import mips_alu_pkg::*;
import mips_isa_pkg::*;

localparam int RESET_CYCLES = 4;
localparam int RAND_COUNT   = 40;

localparam logic [STATUS_W-1:0] S_0 = '0;
localparam logic [STATUS_W-1:0] S_Z = STATUS_W'(1) << ST_ZERO;
localparam logic [STATUS_W-1:0] S_N = STATUS_W'(1) << ST_NEG;
localparam logic [STATUS_W-1:0] S_V = STATUS_W'(1) << ST_OVF;
localparam logic [STATUS_W-1:0] S_D = STATUS_W'(1) << ST_DIVZ;

typedef struct {
	string               name;
	instr_t              instr;
	logic [DATA_W-1:0]   rs_val;
	logic [DATA_W-1:0]   rt_val;
	logic [DATA_W-1:0]   exp_result;
	logic [STATUS_W-1:0] exp_status;
} vector_t;

logic                clk;
logic                rst_n;
instr_t              instr;
logic [DATA_W-1:0]   rs_val;
logic [DATA_W-1:0]   rt_val;
logic [DATA_W-1:0]   result;
logic [STATUS_W-1:0] status;

vector_t     vectors[$];
vector_t     pending[$];
logic [31:0] lfsr;
int          cycles;
int          limit;
int          errors;

tb_clock #(.PERIOD(40.0), .RESET_CYCLES(RESET_CYCLES)) u_clock
	( .clk   (clk)
	, .rst_n (rst_n)
	);

mips_execute dut
	( .clk    (clk)
	, .rst_n  (rst_n)
	, .instr  (instr)
	, .rs_val (rs_val)
	, .rt_val (rt_val)
	, .result (result)
	, .status (status)
	);

always @(posedge clk) begin
	cycles++;
	if (cycles > limit) begin
		$display("timeout: the tests did not finish within %0d cycles", limit);
		$display("TB FAILED");
		$fatal(1, "run stopped by the cycle limit");
	end
end

function automatic instr_t r_op(input logic [5:0] funct, input logic [4:0] sh);
	instr_t w;
	w = '0;
	w.r.opcode = OP_SPECIAL;
	w.r.rs = 5'd1;
	w.r.rt = 5'd2;
	w.r.rd = 5'd3;
	w.r.shamt = sh;
	w.r.funct = funct;
	return w;
endfunction

function automatic instr_t i_op(input logic [5:0] op, input logic [15:0] imm);
	instr_t w;
	w = '0;
	w.i.opcode = op;
	w.i.rs = 5'd1;
	w.i.rt = 5'd2;
	w.i.imm = imm;
	return w;
endfunction

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr = lfsr_step(lfsr);
		v = {v[30:0], lfsr[0]};
	end
endtask

task automatic expect_equal(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
	if (actual !== expected) begin
		errors++;
		$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	end
endtask

task automatic add_vector(input string name, input instr_t w, input logic [DATA_W-1:0] rs,
		input logic [DATA_W-1:0] rt, input logic [DATA_W-1:0] res,
		input logic [STATUS_W-1:0] st);
	vector_t v;
	v.name = name;
	v.instr = w;
	v.rs_val = rs;
	v.rt_val = rt;
	v.exp_result = res;
	v.exp_status = st;
	vectors.push_back(v);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed vectors with expected values worked out by hand
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic load_vectors();
	add_vector("add", r_op(FN_ADD, 0), 32'h5, 32'h7, 32'hc, S_0);
	add_vector("add ovf", r_op(FN_ADD, 0), 32'h7fffffff, 32'h1, 32'h80000000, S_N | S_V);
	add_vector("sub ovf", r_op(FN_SUB, 0), 32'h80000000, 32'h1, 32'h7fffffff, S_V);
	add_vector("subu zero", r_op(FN_SUBU, 0), 32'h9, 32'h9, 32'h0, S_Z);
	add_vector("and", r_op(FN_AND, 0), 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, S_N);
	add_vector("or", r_op(FN_OR, 0), 32'h0f0f0000, 32'h000000ff, 32'h0f0f00ff, S_0);
	add_vector("xor", r_op(FN_XOR, 0), 32'hffff0000, 32'hff00ff00, 32'h00ffff00, S_0);
	add_vector("nor", r_op(FN_NOR, 0), 32'h0, 32'h0, 32'hffffffff, S_N);
	add_vector("slt", r_op(FN_SLT, 0), 32'hffffffff, 32'h1, 32'h1, S_0);
	add_vector("sltu", r_op(FN_SLTU, 0), 32'hffffffff, 32'h1, 32'h0, S_Z);
	add_vector("addi", i_op(OP_ADDI, 16'hfffb), 32'ha, 32'h0, 32'h5, S_0);
	add_vector("addiu neg", i_op(OP_ADDIU, 16'h8000), 32'h0, 32'h0, 32'hffff8000, S_N);
	add_vector("slti", i_op(OP_SLTI, 16'hffff), 32'hfffffff0, 32'h0, 32'h1, S_0);
	add_vector("sltiu", i_op(OP_SLTIU, 16'hffff), 32'h5, 32'h0, 32'h1, S_0);
	add_vector("andi", i_op(OP_ANDI, 16'h8001), 32'hffffffff, 32'h0, 32'h8001, S_0);
	add_vector("ori b15", i_op(OP_ORI, 16'h8000), 32'h12340000, 32'h0, 32'h12348000, S_0);
	add_vector("xori", i_op(OP_XORI, 16'hffff), 32'h0000ffff, 32'h0, 32'h0, S_Z);
	add_vector("lui", i_op(OP_LUI, 16'h8765), 32'h1, 32'h0, 32'h87650000, S_N);
	add_vector("sll", r_op(FN_SLL, 31), 32'h0, 32'h1, 32'h80000000, S_N);
	add_vector("srl", r_op(FN_SRL, 4), 32'h0, 32'h80000000, 32'h08000000, S_0);
	add_vector("sra neg", r_op(FN_SRA, 4), 32'h0, 32'h80000000, 32'hf8000000, S_N);
	add_vector("sllv 36", r_op(FN_SLLV, 0), 32'h24, 32'hf, 32'hf0, S_0);
	add_vector("srlv 63", r_op(FN_SRLV, 0), 32'h3f, 32'hffffffff, 32'h1, S_0);
	add_vector("srav", r_op(FN_SRAV, 0), 32'h8, 32'hff000000, 32'hffff0000, S_N);
	add_vector("multu", r_op(FN_MULTU, 0), 32'hffffffff, 32'hffffffff, 32'h1, S_0);
	add_vector("multu hi", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'hfffffffe, S_N);
	add_vector("multu lo", r_op(FN_MFLO, 0), 32'h0, 32'h0, 32'h1, S_0);
	add_vector("mult", r_op(FN_MULT, 0), 32'hfffffffe, 32'h3, 32'hfffffffa, S_N);
	add_vector("mult hi", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'hffffffff, S_N);
	add_vector("mult lo", r_op(FN_MFLO, 0), 32'h0, 32'h0, 32'hfffffffa, S_N);
	add_vector("div", r_op(FN_DIV, 0), 32'hfffffff9, 32'h2, 32'hfffffffd, S_N);
	add_vector("div rem", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'hffffffff, S_N);
	add_vector("div quot", r_op(FN_MFLO, 0), 32'h0, 32'h0, 32'hfffffffd, S_N);
	add_vector("div negdiv", r_op(FN_DIV, 0), 32'h7, 32'hfffffffe, 32'hfffffffd, S_N);
	add_vector("negdiv rem", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'h1, S_0);
	add_vector("divu", r_op(FN_DIVU, 0), 32'hfffffff9, 32'h2, 32'h7ffffffc, S_0);
	add_vector("divu rem", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'h1, S_0);
	add_vector("divu quot", r_op(FN_MFLO, 0), 32'h0, 32'h0, 32'h7ffffffc, S_0);
	add_vector("divu by 0", r_op(FN_DIVU, 0), 32'h12345678, 32'h0, 32'hffffffff, S_N | S_D);
	add_vector("divu0 rem", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'h12345678, S_0);
	add_vector("div by 0", r_op(FN_DIV, 0), 32'h80000000, 32'h0, 32'hffffffff, S_N | S_D);
	add_vector("div0 rem", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'h80000000, S_N);
	add_vector("div min", r_op(FN_DIV, 0), 32'h80000000, 32'hffffffff, 32'h80000000, S_N);
	add_vector("min rem", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'h0, S_Z);
	add_vector("mthi", r_op(FN_MTHI, 0), 32'haaaa5555, 32'h0, 32'haaaa5555, S_N);
	add_vector("mthi lo", r_op(FN_MFLO, 0), 32'h0, 32'h0, 32'h80000000, S_N);
	add_vector("mthi hi", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'haaaa5555, S_N);
	add_vector("mtlo", r_op(FN_MTLO, 0), 32'h01234567, 32'h0, 32'h01234567, S_0);
	add_vector("mtlo hi", r_op(FN_MFHI, 0), 32'h0, 32'h0, 32'haaaa5555, S_N);
	add_vector("mtlo lo", r_op(FN_MFLO, 0), 32'h0, 32'h0, 32'h01234567, S_0);
	add_vector("bad funct", r_op(6'h3f, 0), 32'h11, 32'h22, 32'h0, S_Z);
	add_vector("bad opcode", i_op(6'h3f, 16'h1234), 32'h11, 32'h22, 32'h0, S_Z);
endtask

// random R-type op with its expected result from the ALU rules
task automatic random_vector(output vector_t v);
	logic [31:0] pick;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic [32:0] wide;
	logic        ovf;
	logic [5:0]  funct;
	draw_bits(3, pick);
	draw_bits(32, a);
	draw_bits(32, b);
	ovf = 1'b0;
	case (pick % 6)
		0: begin
			funct = FN_ADD;
			// sign-extended sum overflows when the top two bits disagree
			wide = {a[31], a} + {b[31], b};
			res = wide[31:0];
			ovf = wide[32] != wide[31];
		end
		1: begin
			funct = FN_SUB;
			wide = {a[31], a} - {b[31], b};
			res = wide[31:0];
			ovf = wide[32] != wide[31];
		end
		2: begin
			funct = FN_AND;
			res = a & b;
		end
		3: begin
			funct = FN_XOR;
			res = a ^ b;
		end
		4: begin
			funct = FN_SLT;
			res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		end
		default: begin
			funct = FN_SLTU;
			res = (a < b) ? 32'd1 : 32'd0;
		end
	endcase
	v.name = $sformatf("random funct %h", funct);
	v.instr = r_op(funct, 0);
	v.rs_val = a;
	v.rt_val = b;
	v.exp_result = res;
	v.exp_status = '0;
	v.exp_status[ST_ZERO] = (res == '0);
	v.exp_status[ST_NEG] = res[31];
	v.exp_status[ST_OVF] = ovf;
endtask

task automatic check_oldest();
	vector_t v;
	v = pending.pop_front();
	expect_equal({v.name, " result"}, v.exp_result, result);
	expect_equal({v.name, " status"}, DATA_W'(v.exp_status), DATA_W'(status));
	expect_equal({v.name, " assertions"}, '0, DATA_W'(dut.u_sva.fails));
endtask

// called on a falling edge; the entry is checked EXEC_DELAY rising edges later
task automatic run_vector(input vector_t v);
	instr = v.instr;
	rs_val = v.rs_val;
	rt_val = v.rt_val;
	pending.push_back(v);
	@(negedge clk);
	if (pending.size() == EXEC_DELAY)
		check_oldest();
endtask

task automatic drain_pending();
	while (pending.size() > 0) begin
		instr = '0;
		rs_val = '0;
		rt_val = '0;
		@(negedge clk);
		check_oldest();
	end
endtask

initial begin
	vector_t v;
	instr = '0;
	rs_val = '0;
	rt_val = '0;
	lfsr = 32'd76;
	cycles = 0;
	errors = 0;
	load_vectors();
	limit = 2 * (vectors.size() + RAND_COUNT + RESET_CYCLES);
	wait (rst_n === 1'b1);
	// no edge has passed since release so the delay stages still hold zero
	expect_equal("reset result", '0, result);
	expect_equal("reset status", '0, DATA_W'(status));
	foreach (vectors[k])
		run_vector(vectors[k]);
	repeat (RAND_COUNT) begin
		random_vector(v);
		run_vector(v);
	end
	drain_pending();
	if (errors == 0)
		$display("TB PASSED");
	else
		$display("TB FAILED");
	$finish;
end

endmodule
